// ==== project.f ====
+incdir+verilog
verilog/rename_pkg.sv
verilog/rename_spec_map.sv
verilog/rename_freelist.sv
verilog/rename_commit_map.sv
verilog/rename_top.sv
tests/rename_assertions.sv
tests/rename_tb.sv

// ==== tests/rename_tb.sv ====
// testbench for the integer rename stage.
// plays the reorder buffer with random rename groups and in-order
// commits from an xorshift stream. a model of the spec map, commit
// map and free list is checked against the DUT every cycle.

`timescale 1ns/1ns

`include "rename_macros.svh"

module rename_tb;

  localparam int CLK_PERIOD = 40;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_CYCLES = 4000;
  localparam int TIMEOUT_NS = (NUM_CYCLES + RESET_CYCLES + 8) * CLK_PERIOD * 2;

  // one renamed slot waiting to commit.
  typedef struct packed {
    logic                     has_rd;
    rename_pkg::commit_slot_t slot;
  } rob_entry_t;

  logic                     i_clk;
  logic                     i_reset_n;
  logic                     i_rename_valid;
  rename_pkg::rename_req_t  i_rename;
  logic                     o_rename_ready;
  rename_pkg::rename_rsp_t  o_rename;
  rename_pkg::commit_upd_t  i_commit;
  rename_pkg::rnid_map_t    o_commit_map;

  // model state.
  rename_pkg::rnid_map_t    m_spec;
  rename_pkg::rnid_map_t    m_commit;
  logic [`RN_PHYS_REGS-1:0] m_free;
  rename_pkg::rename_rsp_t  exp_rsp;
  rob_entry_t               rob[$];
  logic [31:0]              rng_state;

  rename_top UUT (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_rename_valid (i_rename_valid),
    .i_rename       (i_rename),
    .o_rename_ready (o_rename_ready),
    .o_rename       (o_rename),
    .i_commit       (i_commit),
    .o_commit_map   (o_commit_map)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("** FAIL **");
    $fatal(1, "watchdog expired");
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // half the picks land on x0..x7 so groups often share registers.
  function automatic rename_pkg::reg_idx_t pick_reg();
    logic [31:0] r;
    r = next_rand();
    return r[8] ? rename_pkg::reg_idx_t'(r[2:0]) : rename_pkg::reg_idx_t'(r[4:0]);
  endfunction

  function automatic int count_free();
    int n;
    n = 0;
    for (int i = 0; i < `RN_PHYS_REGS; i++) begin
      n += m_free[i];
    end
    return n;
  endfunction

  // takes the lowest free id out of the model free vector.
  function automatic rename_pkg::rnid_t take_lowest_free();
    for (int i = 0; i < `RN_PHYS_REGS; i++) begin
      if (m_free[i]) begin
        m_free[i] = 1'b0;
        return rename_pkg::rnid_t'(i);
      end
    end
    return '0;
  endfunction

  task automatic check_value(string name, logic [191:0] got, logic [191:0] exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      $display("** FAIL **");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic check_response();
    for (int s = 0; s < `RN_WIDTH; s++) begin
      check_value($sformatf("o_rename.slot[%0d].valid", s), o_rename.slot[s].valid,
                  exp_rsp.slot[s].valid);
      if (exp_rsp.slot[s].valid) begin
        check_value($sformatf("o_rename.slot[%0d].rd_rnid", s), o_rename.slot[s].rd_rnid,
                    exp_rsp.slot[s].rd_rnid);
        check_value($sformatf("o_rename.slot[%0d].rd_old_rnid", s),
                    o_rename.slot[s].rd_old_rnid, exp_rsp.slot[s].rd_old_rnid);
        check_value($sformatf("o_rename.slot[%0d].rs1_rnid", s), o_rename.slot[s].rs1_rnid,
                    exp_rsp.slot[s].rs1_rnid);
        check_value($sformatf("o_rename.slot[%0d].rs2_rnid", s), o_rename.slot[s].rs2_rnid,
                    exp_rsp.slot[s].rs2_rnid);
      end
    end
  endtask

  // picks this cycle's rename group and commit group and drives them.
  task automatic drive_cycle(int cyc);
    logic [31:0] r;
    int n;
    int odds;
    rob_entry_t e;
    r = next_rand();
    i_rename_valid = (r[2:0] < 3'd5);
    i_rename = '0;
    i_rename.slot[0].valid = (r[5:3] != 3'd0);
    i_rename.slot[1].valid = (r[7:6] != 2'd0);
    for (int s = 0; s < `RN_WIDTH; s++) begin
      i_rename.slot[s].rd_regidx = pick_reg();
      i_rename.slot[s].rs1_regidx = pick_reg();
      i_rename.slot[s].rs2_regidx = pick_reg();
    end
    // slow commit phases drain the free list and force stalls.
    odds = ((cyc / 250) % 2 == 1) ? 2 : 6;
    i_commit = '0;
    if ((int'(r[10:8]) < odds) && (rob.size() > 0)) begin
      n = (r[11] && (rob.size() > 1)) ? 2 : 1;
      for (int s = 0; s < n; s++) begin
        e = rob.pop_front();
        i_commit.rnid_valid[s] = e.has_rd;
        i_commit.slot[s] = e.slot;
      end
      i_commit.commit = 1'b1;
      // only a rare flushing group carries dead slots.
      if (r[16:12] == 5'd0) begin
        i_commit.except_valid[(n == 2) ? int'(r[17]) : 0] = 1'b1;
        i_commit.except_type = rename_pkg::except_t'((r[19:18] == 2'd3) ? 2'd2 : r[19:18]);
        i_commit.dead_id = r[21:20] & ((n == 2) ? 2'b11 : 2'b01);
      end
    end
  endtask

  // allocates ids for an accepted group, updates the spec map and queues the slots.
  task automatic model_rename(rename_pkg::rename_req_t req);
    rename_pkg::rename_req_slot_t rq;
    rename_pkg::rnid_t new_id;
    logic writes;
    for (int s = 0; s < `RN_WIDTH; s++) begin
      rq = req.slot[s];
      writes = rq.valid && (rq.rd_regidx != '0);
      new_id = writes ? take_lowest_free() : '0;
      // reads see the map already written by older slots of the group.
      exp_rsp.slot[s].valid = rq.valid;
      exp_rsp.slot[s].rd_rnid = new_id;
      exp_rsp.slot[s].rd_old_rnid = m_spec[rq.rd_regidx];
      exp_rsp.slot[s].rs1_rnid = m_spec[rq.rs1_regidx];
      exp_rsp.slot[s].rs2_rnid = m_spec[rq.rs2_regidx];
      if (writes) begin
        m_spec[rq.rd_regidx] = new_id;
      end
      // an x0 destination still commits with its id valid and releases id 0.
      if (rq.valid) begin
        rob.push_back({rq.valid, rq.rd_regidx, new_id, exp_rsp.slot[s].rd_old_rnid});
      end
    end
  endtask

  task automatic model_commit(rename_pkg::commit_upd_t upd);
    logic dead;
    rename_pkg::rnid_t rel;
    if (upd.commit) begin
      for (int s = 0; s < `RN_WIDTH; s++) begin
        dead = upd.dead_id[s] ||
               (upd.except_valid[s] && (upd.except_type != rename_pkg::EXC_SILENT_FLUSH));
        if (upd.rnid_valid[s]) begin
          rel = dead ? upd.slot[s].rd_rnid : upd.slot[s].rd_old_rnid;
          if (rel != '0) begin
            m_free[rel] = 1'b1;
          end
          if (!dead) begin
            m_commit[upd.slot[s].rd_regidx] = upd.slot[s].rd_rnid;
          end
        end
      end
      // flush restores both speculative structures from the commit map.
      if (|upd.except_valid) begin
        m_spec = m_commit;
        m_free = '1;
        for (int a = 0; a < `RN_ARCH_REGS; a++) begin
          m_free[m_commit[a]] = 1'b0;
        end
        rob.delete();
      end
    end
  endtask

  initial begin
    int need;
    logic flush;
    logic ready;
    rng_state = 32'd51646;
    i_reset_n = 1'b0;
    i_rename_valid = 1'b0;
    i_rename = '0;
    i_commit = '0;
    for (int a = 0; a < `RN_ARCH_REGS; a++) begin
      m_spec[a] = rename_pkg::rnid_t'(a);
      m_commit[a] = rename_pkg::rnid_t'(a);
    end
    m_free = {{(`RN_PHYS_REGS - `RN_ARCH_REGS){1'b1}}, {`RN_ARCH_REGS{1'b0}}};
    exp_rsp = '0;
    repeat (RESET_CYCLES) @(posedge i_clk);
    #5;
    check_value("o_rename_ready", o_rename_ready, 1'b0);
    check_response();
    i_reset_n = 1'b1;
    // ready comes up one edge after reset is released.
    @(posedge i_clk);
    for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
      #5;
      drive_cycle(cyc);
      #5;
      check_response();
      check_value("o_commit_map", o_commit_map, m_commit);
      check_value("free list assertion failures", UUT.u_freelist.u_fl_assert.fail_count, 0);
      flush = i_commit.commit && (|i_commit.except_valid);
      need = 0;
      for (int s = 0; s < `RN_WIDTH; s++) begin
        need += (i_rename.slot[s].valid && (i_rename.slot[s].rd_regidx != '0));
      end
      ready = !flush && (count_free() >= need);
      check_value("o_rename_ready", o_rename_ready, ready);
      exp_rsp = '0;
      if (i_rename_valid && ready) begin
        model_rename(i_rename);
      end
      model_commit(i_commit);
      @(posedge i_clk);
    end
    #5;
    i_rename_valid = 1'b0;
    i_commit = '0;
    #5;
    check_response();
    check_value("o_commit_map", o_commit_map, m_commit);
    check_value("free list assertion failures", UUT.u_freelist.u_fl_assert.fail_count, 0);
    $display("** PASS **");
    $finish;
  end

endmodule

// ==== tests/rename_assertions.sv ====
// free list checks, bound into the free list.
// allocation only takes free ids, the two ids of a group differ,
// a commit never frees an id that is already free, and no rename
// is allowed while a flush restores the maps.

`timescale 1ns/1ns

`include "rename_macros.svh"

module rename_assertions (
  input logic                              i_clk,
  input logic                              i_reset_n,
  input rename_pkg::slot_mask_t            i_need,
  input logic                              i_accept,
  input rename_pkg::slot_mask_t            i_release,
  input rename_pkg::rnid_t [`RN_WIDTH-1:0] i_release_rnid,
  input logic                              i_flush,
  input rename_pkg::rnid_t [`RN_WIDTH-1:0] o_alloc_rnid,
  input logic                              o_ready,
  input logic [`RN_PHYS_REGS-1:0]          r_free
);

  // failures so far, read by the testbench.
  int unsigned fail_count = 0;

  for (genvar s = 0; s < `RN_WIDTH; s++) begin : g_slot
    a_alloc_free: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      (i_accept && i_need[s]) |-> r_free[o_alloc_rnid[s]])
      else begin
        $error("slot %0d allocated id %0d which was not free", s, o_alloc_rnid[s]);
        fail_count++;
      end

    // a flush rebuilds the vector, so releases then have no effect.
    a_release_busy: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      (i_release[s] && !i_flush) |-> !r_free[i_release_rnid[s]])
      else begin
        $error("slot %0d released id %0d which was already free", s, i_release_rnid[s]);
        fail_count++;
      end
  end

  a_alloc_distinct: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_accept && (&i_need)) |-> (o_alloc_rnid[0] != o_alloc_rnid[1]))
    else begin
      $error("both slots were given id %0d", o_alloc_rnid[0]);
      fail_count++;
    end

  a_flush_not_ready: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_flush |-> !o_ready)
    else begin
      $error("ready was high during a flush");
      fail_count++;
    end

endmodule

bind rename_freelist rename_assertions u_fl_assert (
  .i_clk          (i_clk),
  .i_reset_n      (i_reset_n),
  .i_need         (i_need),
  .i_accept       (i_accept),
  .i_release      (i_release),
  .i_release_rnid (i_release_rnid),
  .i_flush        (i_flush),
  .o_alloc_rnid   (o_alloc_rnid),
  .o_ready        (o_ready),
  .r_free         (r_free)
);

// ==== verilog/rename_top.sv ====
// integer rename stage.
// ties the speculative map, the free list and the commit map
// together, forms rename acceptance, the flush pulse and the ids
// released by each commit group.

`timescale 1ns/1ns

`include "rename_macros.svh"

module rename_top (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  logic                    i_rename_valid,
  input  rename_pkg::rename_req_t i_rename,
  output logic                    o_rename_ready,
  output rename_pkg::rename_rsp_t o_rename,
  input  rename_pkg::commit_upd_t i_commit,
  output rename_pkg::rnid_map_t   o_commit_map
);

  rename_pkg::slot_mask_t             w_need;
  rename_pkg::slot_mask_t             w_dead;
  rename_pkg::slot_mask_t             w_release;
  rename_pkg::rnid_t [`RN_WIDTH-1:0]  w_release_rnid;
  rename_pkg::rnid_t [`RN_WIDTH-1:0]  w_alloc_rnid;
  rename_pkg::rnid_map_t              w_commit_map_next;
  logic                               w_accept;
  logic                               w_flush;

  // any exception in a commit group flushes the pipeline.
  assign w_flush = i_commit.commit && (|i_commit.except_valid);
  assign w_accept = i_rename_valid && o_rename_ready;
  assign w_dead = rename_pkg::dead_mask(i_commit);

  always_comb begin
    for (int s = 0; s < `RN_WIDTH; s++) begin
      // x0 destinations take no id.
      w_need[s] = i_rename.slot[s].valid && (i_rename.slot[s].rd_regidx != '0);
      // live slots free the old id, dead slots free their own.
      w_release_rnid[s] = w_dead[s] ? i_commit.slot[s].rd_rnid
                                    : i_commit.slot[s].rd_old_rnid;
      w_release[s] = i_commit.commit && i_commit.rnid_valid[s] &&
                     (w_release_rnid[s] != '0);
    end
  end

  rename_spec_map u_spec_map (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_accept          (w_accept),
    .i_req             (i_rename),
    .i_alloc_rnid      (w_alloc_rnid),
    .i_flush           (w_flush),
    .i_commit_map_next (w_commit_map_next),
    .o_rsp             (o_rename)
  );

  rename_freelist u_freelist (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_need            (w_need),
    .i_accept          (w_accept),
    .i_release         (w_release),
    .i_release_rnid    (w_release_rnid),
    .i_flush           (w_flush),
    .i_commit_map_next (w_commit_map_next),
    .o_alloc_rnid      (w_alloc_rnid),
    .o_ready           (o_rename_ready)
  );

  rename_commit_map u_commit_map (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_commit          (i_commit),
    .o_commit_map_next (w_commit_map_next),
    .o_commit_map      (o_commit_map)
  );

endmodule

// ==== verilog/rename_commit_map.sv ====
// committed rename map.
// holds the architectural to physical mapping of retired
// instructions, updated once per commit group. dead slots and slots
// with a non silent exception leave the map alone.

`timescale 1ns/1ns

`include "rename_macros.svh"

module rename_commit_map (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  rename_pkg::commit_upd_t i_commit,
  output rename_pkg::rnid_map_t   o_commit_map_next,
  output rename_pkg::rnid_map_t   o_commit_map
);

  rename_pkg::rnid_map_t  r_map;
  rename_pkg::rnid_map_t  w_map_next;
  rename_pkg::slot_mask_t w_dead;

  assign w_dead = rename_pkg::dead_mask(i_commit);

  always_comb begin
    w_map_next = r_map;
    if (i_commit.commit) begin
      // slot order, a younger write to the same rd wins.
      for (int s = 0; s < `RN_WIDTH; s++) begin
        if (i_commit.rnid_valid[s] && !w_dead[s]) begin
          w_map_next[i_commit.slot[s].rd_regidx] = i_commit.slot[s].rd_rnid;
        end
      end
    end
    // x0 is hard-wired to id 0.
    w_map_next[0] = '0;
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      // identity map out of reset.
      for (int r = 0; r < `RN_ARCH_REGS; r++) begin
        r_map[r] <= rename_pkg::rnid_t'(r);
      end
    end else begin
      r_map <= w_map_next;
    end
  end

  // next state feeds the flush restore of the spec map and free list.
  assign o_commit_map_next = w_map_next;
  assign o_commit_map = r_map;

endmodule

// ==== verilog/rename_freelist.sv ====
// physical id free list.
// one bit per id, allocation takes the lowest free ids first,
// commit releases set bits back and a flush rebuilds the vector as
// every id the next commit map does not reference.

`timescale 1ns/1ns

`include "rename_macros.svh"

module rename_freelist (
  input  logic                                i_clk,
  input  logic                                i_reset_n,
  input  rename_pkg::slot_mask_t              i_need,
  input  logic                                i_accept,
  input  rename_pkg::slot_mask_t              i_release,
  input  rename_pkg::rnid_t [`RN_WIDTH-1:0]   i_release_rnid,
  input  logic                                i_flush,
  input  rename_pkg::rnid_map_t               i_commit_map_next,
  output rename_pkg::rnid_t [`RN_WIDTH-1:0]   o_alloc_rnid,
  output logic                                o_ready
);

  localparam int CNT_W = $clog2(`RN_PHYS_REGS) + 1;

  logic [`RN_PHYS_REGS-1:0] r_free;
  logic [`RN_PHYS_REGS-1:0] w_free_next;
  logic                     r_ready_en;
  logic                     w_found_first;
  logic                     w_found_second;
  rename_pkg::rnid_t        w_first;
  rename_pkg::rnid_t        w_second;
  logic [CNT_W-1:0]         w_free_cnt;
  logic [CNT_W-1:0]         w_need_cnt;

  // lowest and second lowest free ids, plus the free count.
  always_comb begin
    w_found_first = 1'b0;
    w_found_second = 1'b0;
    w_first = '0;
    w_second = '0;
    w_free_cnt = '0;
    for (int i = 0; i < `RN_PHYS_REGS; i++) begin
      if (r_free[i]) begin
        if (!w_found_first) begin
          w_first = rename_pkg::rnid_t'(i);
          w_found_first = 1'b1;
        end else if (!w_found_second) begin
          w_second = rename_pkg::rnid_t'(i);
          w_found_second = 1'b1;
        end
      end
      w_free_cnt = w_free_cnt + {{(CNT_W-1){1'b0}}, r_free[i]};
    end
  end

  // slot 1 takes the lowest id when slot 0 needs none.
  assign o_alloc_rnid[0] = w_first;
  assign o_alloc_rnid[1] = i_need[0] ? w_second : w_first;

  always_comb begin
    w_need_cnt = '0;
    for (int s = 0; s < `RN_WIDTH; s++) begin
      w_need_cnt = w_need_cnt + {{(CNT_W-1){1'b0}}, i_need[s]};
    end
  end

  // no rename in a flush cycle, the maps are being restored.
  assign o_ready = r_ready_en && !i_flush && (w_free_cnt >= w_need_cnt);

  always_comb begin
    w_free_next = r_free;
    if (i_flush) begin
      // free is whatever the committed state no longer points at.
      w_free_next = '1;
      for (int r = 0; r < `RN_ARCH_REGS; r++) begin
        w_free_next[i_commit_map_next[r]] = 1'b0;
      end
    end else begin
      if (i_accept) begin
        for (int s = 0; s < `RN_WIDTH; s++) begin
          if (i_need[s]) begin
            w_free_next[o_alloc_rnid[s]] = 1'b0;
          end
        end
      end
      // released ids are never the ones just allocated.
      for (int s = 0; s < `RN_WIDTH; s++) begin
        if (i_release[s]) begin
          w_free_next[i_release_rnid[s]] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      // ids above the identity mapping start free.
      r_free <= {{(`RN_PHYS_REGS-`RN_ARCH_REGS){1'b1}}, {`RN_ARCH_REGS{1'b0}}};
      r_ready_en <= 1'b0;
    end else begin
      r_free <= w_free_next;
      r_ready_en <= 1'b1;
    end
  end

endmodule

// ==== verilog/rename_spec_map.sv ====
// speculative rename map.
// looks up source and old destination ids for a rename group, with
// bypass from earlier slots of the same group, writes the new ids on
// acceptance and reloads from the next commit map on flush.

`timescale 1ns/1ns

`include "rename_macros.svh"

module rename_spec_map (
  input  logic                                i_clk,
  input  logic                                i_reset_n,
  input  logic                                i_accept,
  input  rename_pkg::rename_req_t             i_req,
  input  rename_pkg::rnid_t [`RN_WIDTH-1:0]   i_alloc_rnid,
  input  logic                                i_flush,
  input  rename_pkg::rnid_map_t               i_commit_map_next,
  output rename_pkg::rename_rsp_t             o_rsp
);

  rename_pkg::rnid_map_t                r_map;
  rename_pkg::rnid_map_t                w_map_next;
  rename_pkg::rnid_t [`RN_WIDTH-1:0]    w_new_rnid;
  rename_pkg::rename_rsp_t              w_rsp;
  rename_pkg::rename_rsp_t              r_rsp;
  rename_pkg::slot_mask_t               w_writes;
  rename_pkg::slot_mask_t               r_rsp_valid;

  // lookups, later slots see the newest earlier write in the group.
  always_comb begin
    w_rsp = '0;
    for (int s = 0; s < `RN_WIDTH; s++) begin
      w_writes[s] = i_req.slot[s].valid && (i_req.slot[s].rd_regidx != '0);
      // x0 gets no new id.
      w_new_rnid[s] = w_writes[s] ? i_alloc_rnid[s] : '0;
    end
    for (int s = 0; s < `RN_WIDTH; s++) begin
      w_rsp.slot[s].rd_rnid = w_new_rnid[s];
      w_rsp.slot[s].rd_old_rnid = r_map[i_req.slot[s].rd_regidx];
      w_rsp.slot[s].rs1_rnid = r_map[i_req.slot[s].rs1_regidx];
      w_rsp.slot[s].rs2_rnid = r_map[i_req.slot[s].rs2_regidx];
      for (int p = 0; p < s; p++) begin
        if (w_writes[p] && (i_req.slot[p].rd_regidx == i_req.slot[s].rd_regidx)) begin
          w_rsp.slot[s].rd_old_rnid = w_new_rnid[p];
        end
        if (w_writes[p] && (i_req.slot[p].rd_regidx == i_req.slot[s].rs1_regidx)) begin
          w_rsp.slot[s].rs1_rnid = w_new_rnid[p];
        end
        if (w_writes[p] && (i_req.slot[p].rd_regidx == i_req.slot[s].rs2_regidx)) begin
          w_rsp.slot[s].rs2_rnid = w_new_rnid[p];
        end
      end
    end
  end

  // map update, flush has priority over a rename.
  always_comb begin
    w_map_next = r_map;
    if (i_flush) begin
      w_map_next = i_commit_map_next;
    end else if (i_accept) begin
      // slot order, so the last slot wins on a shared rd.
      for (int s = 0; s < `RN_WIDTH; s++) begin
        if (w_writes[s]) begin
          w_map_next[i_req.slot[s].rd_regidx] = w_new_rnid[s];
        end
      end
    end
    // x0 stays on id 0.
    w_map_next[0] = '0;
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int r = 0; r < `RN_ARCH_REGS; r++) begin
        r_map[r] <= rename_pkg::rnid_t'(r);
      end
      r_rsp_valid <= '0;
    end else begin
      r_map <= w_map_next;
      for (int s = 0; s < `RN_WIDTH; s++) begin
        r_rsp_valid[s] <= i_accept && i_req.slot[s].valid;
      end
    end
  end

  // response payload, only sampled on acceptance.
  always_ff @(posedge i_clk) begin
    if (i_accept) begin
      r_rsp <= w_rsp;
    end
  end

  always_comb begin
    o_rsp = r_rsp;
    for (int s = 0; s < `RN_WIDTH; s++) begin
      o_rsp.slot[s].valid = r_rsp_valid[s];
    end
  end

endmodule

// ==== verilog/rename_pkg.sv ====
// rename stage package.
// id types, exception encoding and the packed structs that carry
// rename groups, rename responses and commit groups between blocks.

`include "rename_macros.svh"

package rename_pkg;

  localparam int REGIDX_W = $clog2(`RN_ARCH_REGS);
  localparam int RNID_W = $clog2(`RN_PHYS_REGS);

  typedef logic [REGIDX_W-1:0] reg_idx_t;
  typedef logic [RNID_W-1:0] rnid_t;
  typedef logic [`RN_WIDTH-1:0] slot_mask_t;

  // silent flush keeps the excepting slot live.
  typedef enum logic [1:0] {
    EXC_NONE         = 2'd0,
    EXC_SILENT_FLUSH = 2'd1,
    EXC_FLUSH        = 2'd2
  } except_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd_regidx;
    reg_idx_t rs1_regidx;
    reg_idx_t rs2_regidx;
  } rename_req_slot_t;

  typedef struct packed {
    rename_req_slot_t [`RN_WIDTH-1:0] slot;
  } rename_req_t;

  typedef struct packed {
    logic  valid;
    rnid_t rd_rnid;
    rnid_t rd_old_rnid;
    rnid_t rs1_rnid;
    rnid_t rs2_rnid;
  } rename_rsp_slot_t;

  typedef struct packed {
    rename_rsp_slot_t [`RN_WIDTH-1:0] slot;
  } rename_rsp_t;

  typedef struct packed {
    reg_idx_t rd_regidx;
    rnid_t    rd_rnid;
    rnid_t    rd_old_rnid;
  } commit_slot_t;

  typedef struct packed {
    logic                         commit;
    except_t                      except_type;
    slot_mask_t                   rnid_valid;
    slot_mask_t                   dead_id;
    slot_mask_t                   except_valid;
    commit_slot_t [`RN_WIDTH-1:0] slot;
  } commit_upd_t;

  typedef rnid_t [`RN_ARCH_REGS-1:0] rnid_map_t;

  // slots whose result is discarded at commit.
  // an excepting slot is dead unless the exception is a silent flush.
  function automatic slot_mask_t dead_mask(commit_upd_t upd);
    slot_mask_t mask;
    mask = upd.dead_id;
    if ((|upd.except_valid) && (upd.except_type != EXC_SILENT_FLUSH)) begin
      mask = upd.dead_id | upd.except_valid;
    end
    return mask;
  endfunction

endpackage

// ==== verilog/rename_macros.svh ====
// rename stage sizing.
// architectural and physical register counts and the number of
// rename and commit slots handled per cycle.

`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// integer architectural registers, x0 included.
`define RN_ARCH_REGS 32

// physical register ids shared by the spec map and free list.
`define RN_PHYS_REGS 64

// rename and commit group width.
`define RN_WIDTH 2

`endif
